//--- compile.f
+incdir+hw
hw/ir_pkg.sv
hw/alu_pkg.sv
hw/alu_function_ctrl.sv
hw/alu_slice_array.sv
hw/carry_lookahead.sv
hw/alu_output_stage.sv
hw/cadr_alu_top.sv
sim/cadr_alu_tb.sv

//--- hw/alu_function_ctrl.sv
// ALU function decode from micro-instruction fields and multiply/divide steps.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module alu_function_ctrl import ir_pkg::*, alu_pkg::*; (
   input  wire  [`IR_W-1:0] ir,
   input  wire              iralu,
   input  wire              irjump,
   input  wire  step_kind_e step_kind,
   input  wire              a_sign,
   input  wire              q_lsb,
   output alu_ctrl_t        ctrl
);

   typedef enum logic [1:0] {
      OP_IR     = 2'b00,
      OP_ADD    = 2'b01,
      OP_SUB    = 2'b10,
      OP_PASS_A = 2'b11
   } alu_op_e;

   ir_alu_t irf;
   logic    is_mul;
   logic    is_div;
   logic    div_pos_last;
   logic    div_sub_cond;
   logic    div_add_cond;
   logic    mul_nop;
   logic    alu_add;
   logic    alu_sub;
   alu_op_e op;

   always_comb begin
      irf.osel   = {ir[`IR_OSEL_HI], ir[`IR_OSEL_LO]};
      irf.mode_n = ir[`IR_MODE_N];
      irf.s3     = ir[`IR_S3];
      irf.s2     = ir[`IR_S2];
      irf.s1_n   = ir[`IR_S1_N];
      irf.s0_n   = ir[`IR_S0_N];
      irf.cin    = ir[`IR_CIN];
   end

   assign is_mul = (step_kind == STEP_MUL);
   assign is_div = (step_kind == STEP_DIV);

   assign div_pos_last = q_lsb | irf.s1_n;                       // Remainder bit.
   assign div_sub_cond = is_div & div_pos_last;
   assign div_add_cond = is_div & (irf.s0_n | ~div_pos_last);    // First-step bit.
   assign mul_nop      = is_mul & ~q_lsb;

   // Sign of a swaps the divide add/subtract choice.
   assign alu_add = (div_add_cond & ~a_sign) | (div_sub_cond & a_sign) | is_mul;
   assign alu_sub = mul_nop | (div_sub_cond & ~a_sign) | (div_add_cond & a_sign) | irjump;

   assign op = alu_op_e'({alu_sub, alu_add});

   always_comb begin
      ctrl.osel = osel_e'(irf.osel & {2{iralu}});
      case (op)
         OP_ADD: begin
            ctrl.aluf    = 4'b1001;
            ctrl.alumode = 1'b0;
            ctrl.cin0    = 1'b0;
         end
         OP_SUB: begin
            ctrl.aluf    = 4'b0110;
            ctrl.alumode = 1'b0;
            ctrl.cin0    = ~irjump;                    // Jump compare is A-M-1.
         end
         OP_PASS_A: begin
            ctrl.aluf    = 4'b1111;
            ctrl.alumode = 1'b1;
            ctrl.cin0    = 1'b1;
         end
         default: begin
            ctrl.aluf    = {irf.s3, irf.s2, ~irf.s1_n, ~irf.s0_n};
            ctrl.alumode = ~irf.mode_n;
            ctrl.cin0    = irf.cin;
         end
      endcase
   end

   // A jump compare never shares a cycle with a step.
   a_jump_no_step: assert final ($isunknown({irjump, step_kind}) ||
                                 !(irjump && (step_kind != STEP_NONE)));

endmodule : alu_function_ctrl

`default_nettype wire

//--- hw/alu_output_stage.sv
// Output shifter, output bus and carry registers, and the Q register.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module alu_output_stage import ir_pkg::*, alu_pkg::*; (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire  [`WORD_W-1:0]  result,
   input  wire                 carry_out_comb,
   input  wire  osel_e         osel,
   input  wire  step_kind_e    step_kind,
   input  wire                 step,
   input  wire                 q_load,
   input  wire  [`WORD_W-1:0]  a,
   output logic [`WORD_W-1:0]  ob,
   output logic [`WORD_W-1:0]  q,
   output logic                carry_out
);

   logic [`WORD_W-1:0] ob_next;
   logic               mul_step;
   logic               div_step;

   assign mul_step = step && (step_kind == STEP_MUL);
   assign div_step = step && (step_kind == STEP_DIV);

   always_comb begin
      case (osel)
         OSEL_RIGHT:       ob_next = {carry_out_comb, result[`WORD_W-1:1]};
         OSEL_LEFT:        ob_next = {result[`WORD_W-2:0], q[`WORD_W-1]};
         OSEL_RIGHT_ARITH: ob_next = {result[`WORD_W-1], result[`WORD_W-1:1]};
         default:          ob_next = result;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ob        <= '0;
         carry_out <= 1'b0;
      end else if (step) begin
         ob        <= ob_next;
         carry_out <= carry_out_comb;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         q <= '0;
      end else if (mul_step) begin
         q <= {result[0], q[`WORD_W-1:1]};           // Low product bit in.
      end else if (div_step) begin
         q <= {q[`WORD_W-2:0], ~result[`WORD_W-1]};  // Quotient bit in.
      end else if (q_load) begin
         q <= a;
      end
   end

   a_qload_no_step: assert property (@(posedge clk) disable iff (!rst_n)
      !(q_load && (mul_step || div_step)));

endmodule : alu_output_stage

`default_nettype wire

//--- hw/alu_pkg.sv
// ALU control struct, output-select enum and slice generate/propagate struct.
`default_nettype none

`include "cadr_defs.svh"

package alu_pkg;

   // Output bus shift select.
   typedef enum logic [1:0] {
      OSEL_STRAIGHT    = 2'b00,
      OSEL_RIGHT       = 2'b01,   // Carry out enters bit 31.
      OSEL_LEFT        = 2'b10,   // Q bit 31 enters bit 0.
      OSEL_RIGHT_ARITH = 2'b11    // Sign bit copied.
   } osel_e;

   // Decoded function for the slices, lookahead and output stage.
   typedef struct packed {
      logic [3:0] aluf;      // 74181 select, S3 in bit 3.
      logic       alumode;   // High selects logic mode.
      logic       cin0;      // Active-high carry into slice 0.
      osel_e      osel;
   } alu_ctrl_t;

   // Per-slice carry status, one bit per slice.
   typedef struct packed {
      logic [`NUM_SLICES-1:0] gen;
      logic [`NUM_SLICES-1:0] prop;
   } slice_gp_t;

endpackage : alu_pkg

`default_nettype wire

//--- hw/alu_slice_array.sv
// Eight 74181-style 4-bit ALU slices with per-slice generate and propagate.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module alu_slice_array import alu_pkg::*; (
   input  wire  [`WORD_W-1:0]     a,
   input  wire  [`WORD_W-1:0]     m,
   input  wire  alu_ctrl_t        ctrl,
   input  wire  [`NUM_SLICES-1:0] slice_cin,
   output logic [`WORD_W-1:0]     result,
   output slice_gp_t              gp
);

   logic s0;
   logic s1;
   logic s2;
   logic s3;

   assign {s3, s2, s1, s0} = ctrl.aluf;

   for (genvar s = 0; s < `NUM_SLICES; s++) begin : g_slice
      logic [`SLICE_W-1:0] an;
      logic [`SLICE_W-1:0] bn;
      logic [`SLICE_W-1:0] p;
      logic [`SLICE_W-1:0] g;
      logic [`SLICE_W-1:0] hs;
      logic [`SLICE_W-1:0] c;
      logic                grp_g;

      assign an = a[s*`SLICE_W +: `SLICE_W];
      assign bn = m[s*`SLICE_W +: `SLICE_W];

      // Select lines pick the two addend terms. G is a subset of P.
      assign p  = an | (bn & {`SLICE_W{s0}}) | (~bn & {`SLICE_W{s1}});
      assign g  = an & ((bn & {`SLICE_W{s3}}) | (~bn & {`SLICE_W{s2}}));
      assign hs = p & ~g;

      // Internal carries from the slice carry-in.
      always_comb begin
         c[0] = slice_cin[s];
         for (int i = 1; i < `SLICE_W; i++) begin
            c[i] = g[i-1] | (p[i-1] & c[i-1]);
         end
      end

      always_comb begin
         grp_g = g[0];
         for (int i = 1; i < `SLICE_W; i++) begin
            grp_g = g[i] | (p[i] & grp_g);
         end
      end

      // Logic mode ignores carries.
      assign result[s*`SLICE_W +: `SLICE_W] = ctrl.alumode ? ~hs : (hs ^ c);

      assign gp.gen[s]  = grp_g;
      assign gp.prop[s] = &p;
   end

endmodule : alu_slice_array

`default_nettype wire

//--- hw/cadr_alu_top.sv
// ALU path top level: function decode, slices, lookahead and output stage.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module cadr_alu_top import ir_pkg::*, alu_pkg::*; (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire  [`WORD_W-1:0]  a,
   input  wire  [`WORD_W-1:0]  m,
   input  wire  [`IR_W-1:0]    ir,
   input  wire                 iralu,
   input  wire                 irjump,
   input  wire                 mul,
   input  wire                 div,
   input  wire                 step,
   input  wire                 q_load,
   output logic [`WORD_W-1:0]  ob,
   output logic [`WORD_W-1:0]  q,
   output logic                carry_out
);

   step_kind_e             step_kind;
   alu_ctrl_t              ctrl;
   slice_gp_t              gp;
   logic [`NUM_SLICES-1:0] slice_cin;
   logic [`WORD_W-1:0]     result;
   logic                   carry_out_comb;

   assign step_kind = mul ? STEP_MUL : (div ? STEP_DIV : STEP_NONE);

   alu_function_ctrl u_ctrl (
      .ir        (ir),
      .iralu     (iralu),
      .irjump    (irjump),
      .step_kind (step_kind),
      .a_sign    (a[`WORD_W-1]),
      .q_lsb     (q[0]),
      .ctrl      (ctrl)
   );

   alu_slice_array u_slices (
      .a         (a),
      .m         (m),
      .ctrl      (ctrl),
      .slice_cin (slice_cin),
      .result    (result),
      .gp        (gp)
   );

   carry_lookahead u_cla (
      .gp             (gp),
      .cin0           (ctrl.cin0),
      .slice_cin      (slice_cin),
      .carry_out_comb (carry_out_comb)
   );

   alu_output_stage u_out (
      .clk            (clk),
      .rst_n          (rst_n),
      .result         (result),
      .carry_out_comb (carry_out_comb),
      .osel           (ctrl.osel),
      .step_kind      (step_kind),
      .step           (step),
      .q_load         (q_load),
      .a              (a),
      .ob             (ob),
      .q              (q),
      .carry_out      (carry_out)
   );

endmodule : cadr_alu_top

`default_nettype wire

//--- hw/cadr_defs.svh
// Word, slice and micro-instruction widths and the ALU field bit positions.
`ifndef CADR_DEFS_SVH
`define CADR_DEFS_SVH

// Datapath geometry.
`define WORD_W      32
`define SLICE_W     4
`define NUM_SLICES  8

// Micro-instruction word.
`define IR_W        49

// ALU field bit positions in the micro-instruction.
`define IR_CIN      2
`define IR_S3       3
`define IR_S2       4
`define IR_S0_N     5    // Also the divide first-step bit.
`define IR_S1_N     6    // Also the divide remainder bit.
`define IR_MODE_N   7
`define IR_OSEL_LO  12
`define IR_OSEL_HI  13

`endif

//--- hw/carry_lookahead.sv
// Two-level 74182-style carry lookahead over the eight ALU slices.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module carry_lookahead import alu_pkg::*; (
   input  wire  slice_gp_t        gp,
   input  wire                    cin0,
   output logic [`NUM_SLICES-1:0] slice_cin,
   output logic                   carry_out_comb
);

   localparam int HALF_SLICES = `WORD_W / (2 * `SLICE_W);

   logic [1:0] grp_g;
   logic [1:0] grp_p;
   logic [1:0] grp_cin;

   // First level has one lookahead unit per half-word.
   for (genvar h = 0; h < 2; h++) begin : g_half
      logic [HALF_SLICES-1:0] gh;
      logic [HALF_SLICES-1:0] ph;
      logic [HALF_SLICES-1:0] ch;
      logic                   gg;

      assign gh = gp.gen[h*HALF_SLICES +: HALF_SLICES];
      assign ph = gp.prop[h*HALF_SLICES +: HALF_SLICES];

      always_comb begin
         ch[0] = grp_cin[h];
         gg    = gh[0];
         for (int j = 1; j < HALF_SLICES; j++) begin
            ch[j] = gh[j-1] | (ph[j-1] & ch[j-1]);
            gg    = gh[j] | (ph[j] & gg);
         end
      end

      assign grp_g[h] = gg;
      assign grp_p[h] = &ph;
      assign slice_cin[h*HALF_SLICES +: HALF_SLICES] = ch;
   end

   // Second level.
   assign grp_cin[0]     = cin0;
   assign grp_cin[1]     = grp_g[0] | (grp_p[0] & cin0);
   assign carry_out_comb = grp_g[1] | (grp_p[1] & grp_g[0]) | (grp_p[1] & grp_p[0] & cin0);

   // Final carry agrees with a ripple out of the top slice.
   a_carry_out_ripple: assert final ($isunknown({gp, slice_cin}) ||
      (carry_out_comb == (gp.gen[`NUM_SLICES-1] |
                          (gp.prop[`NUM_SLICES-1] & slice_cin[`NUM_SLICES-1]))));

endmodule : carry_lookahead

`default_nettype wire

//--- hw/ir_pkg.sv
// Micro-instruction ALU field struct and the multiply/divide step kind.
`default_nettype none

package ir_pkg;

   // Step request seen by the ALU on a given cycle.
   typedef enum logic [1:0] {
      STEP_NONE = 2'd0,
      STEP_MUL  = 2'd1,
      STEP_DIV  = 2'd2
   } step_kind_e;

   // ALU-relevant fields pulled out of the micro-instruction.
   typedef struct packed {
      logic [1:0] osel;     // Output shift select.
      logic       mode_n;   // Low selects logic mode.
      logic       s3;
      logic       s2;
      logic       s1_n;     // Stored inverted.
      logic       s0_n;     // Stored inverted.
      logic       cin;      // Carry into bit 0.
   } ir_alu_t;

endpackage : ir_pkg

`default_nettype wire

//--- sim/cadr_alu_tb.sv
// Table-driven testbench for the ALU path with a reference model of control, slices and shifts.
`timescale 1ns/100ps
`default_nettype none

`include "cadr_defs.svh"

module cadr_alu_tb;

   localparam int RESET_CYCLES = 2;

   // Flag bits iralu, irjump, mul and div from the MSB down.
   localparam logic [3:0] F_RAW = 4'b0000;
   localparam logic [3:0] F_ALU = 4'b1000;
   localparam logic [3:0] F_JMP = 4'b0100;
   localparam logic [3:0] F_MUL = 4'b1010;
   localparam logic [3:0] F_DIV = 4'b1001;

   typedef struct packed {
      logic [`WORD_W-1:0] a;
      logic [`WORD_W-1:0] m;
      logic [3:0]         sel;       // True 74181 select, S3 first.
      logic               logic_m;
      logic               cin;
      logic [1:0]         osel;
      logic [3:0]         flags;
      logic               q_load;
      logic [`WORD_W-1:0] q_pre;
   } vec_t;

   typedef struct packed {
      logic [3:0] sel;
      logic       logic_m;
      logic       cin;
   } fn_t;

   localparam fn_t FN_ADD    = {4'b1001, 1'b0, 1'b0};
   localparam fn_t FN_SUB    = {4'b0110, 1'b0, 1'b1};
   localparam fn_t FN_PASS_A = {4'b1111, 1'b1, 1'b1};

   logic               clk;
   logic               rst_n;
   logic [`WORD_W-1:0] a;
   logic [`WORD_W-1:0] m;
   logic [`IR_W-1:0]   ir;
   logic               iralu;
   logic               irjump;
   logic               mul;
   logic               div;
   logic               step;
   logic               q_load;
   logic [`WORD_W-1:0] ob;
   logic [`WORD_W-1:0] q;
   logic               carry_out;

   vec_t               vecs[$];
   string              names[$];
   logic [`WORD_W-1:0] exp_q;
   int                 error_count = 0;
   int                 check_count = 0;
   int                 cycle_count = 0;
   int                 cycle_limit = 1000;

   cadr_alu_top DUT (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .m         (m),
      .ir        (ir),
      .iralu     (iralu),
      .irjump    (irjump),
      .mul       (mul),
      .div       (div),
      .step      (step),
      .q_load    (q_load),
      .ob        (ob),
      .q         (q),
      .carry_out (carry_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("Timeout: run did not finish within %0d cycles", cycle_limit);
         $display("Checks: %0d, errors: %0d", check_count, error_count);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic add_vec(input string name, input logic [`WORD_W-1:0] va,
                          input logic [`WORD_W-1:0] vm, input logic [3:0] sel,
                          input logic logic_m, input logic cin, input logic [1:0] osel,
                          input logic [3:0] flags, input logic ld,
                          input logic [`WORD_W-1:0] q_pre);
      vec_t v;
      v = {va, vm, sel, logic_m, cin, osel, flags, ld, q_pre};
      vecs.push_back(v);
      names.push_back(name);
   endtask

   function automatic logic [`IR_W-1:0] build_ir(input vec_t v);
      logic [`IR_W-1:0] w;
      w = '0;
      w[`IR_CIN]    = v.cin;
      w[`IR_S3]     = v.sel[3];
      w[`IR_S2]     = v.sel[2];
      w[`IR_S1_N]   = ~v.sel[1];
      w[`IR_S0_N]   = ~v.sel[0];
      w[`IR_MODE_N] = ~v.logic_m;
      w[`IR_OSEL_HI:`IR_OSEL_LO] = v.osel;
      return w;
   endfunction

   // 74181 logic column for active-high data.
   function automatic logic [`WORD_W-1:0] logic_181(input logic [3:0] s,
                                                    input logic [`WORD_W-1:0] x,
                                                    input logic [`WORD_W-1:0] y);
      case (s)
         4'b0000: return ~x;
         4'b0001: return ~(x | y);
         4'b0010: return ~x & y;
         4'b0011: return '0;
         4'b0100: return ~(x & y);
         4'b0101: return ~y;
         4'b0110: return x ^ y;
         4'b0111: return x & ~y;
         4'b1000: return ~x | y;
         4'b1001: return ~(x ^ y);
         4'b1010: return y;
         4'b1011: return x & y;
         4'b1100: return '1;
         4'b1101: return x | ~y;
         4'b1110: return x | y;
         default: return x;
      endcase
   endfunction

   // 74181 arithmetic column as two addends plus carry. Minus one is all ones.
   function automatic logic [`WORD_W:0] arith_181(input logic [3:0] s,
                                                  input logic [`WORD_W-1:0] x,
                                                  input logic [`WORD_W-1:0] y,
                                                  input logic c);
      logic [`WORD_W-1:0] p;
      logic [`WORD_W-1:0] r;
      case (s)
         4'b0000: begin p = x;      r = '0;     end
         4'b0001: begin p = x | y;  r = '0;     end
         4'b0010: begin p = x | ~y; r = '0;     end
         4'b0011: begin p = '1;     r = '0;     end
         4'b0100: begin p = x;      r = x & ~y; end
         4'b0101: begin p = x | y;  r = x & ~y; end
         4'b0110: begin p = x;      r = ~y;     end
         4'b0111: begin p = x & ~y; r = '1;     end
         4'b1000: begin p = x;      r = x & y;  end
         4'b1001: begin p = x;      r = y;      end
         4'b1010: begin p = x | ~y; r = x & y;  end
         4'b1011: begin p = x & y;  r = '1;     end
         4'b1100: begin p = x;      r = x;      end
         4'b1101: begin p = x | y;  r = x;      end
         4'b1110: begin p = x | ~y; r = x;      end
         default: begin p = x;      r = '1;     end
      endcase
      return {1'b0, p} + {1'b0, r} + c;
   endfunction

   function automatic fn_t choose_function(input vec_t v, input logic q0);
      fn_t              f;
      logic [`IR_W-1:0] w;
      logic             add_c;
      logic             sub_c;
      logic             tmp;
      w = build_ir(v);
      f = {v.sel, v.logic_m, v.cin};
      if (v.flags[1]) begin
         f = q0 ? FN_ADD : FN_PASS_A;
      end else if (v.flags[0]) begin
         sub_c = q0 | w[`IR_S1_N];
         add_c = ~sub_c | w[`IR_S0_N];
         if (v.a[`WORD_W-1]) begin      // Negative a swaps the choice.
            tmp   = add_c;
            add_c = sub_c;
            sub_c = tmp;
         end
         if (add_c && sub_c)
            f = FN_PASS_A;
         else if (add_c)
            f = FN_ADD;
         else
            f = FN_SUB;
      end else if (v.flags[2]) begin
         f     = FN_SUB;
         f.cin = 1'b0;                  // A minus M minus 1.
      end
      return f;
   endfunction

   task automatic predict(input vec_t v, output logic [`WORD_W-1:0] ob_e, output logic co_e);
      fn_t                f;
      logic [`WORD_W:0]   sum;
      logic [`WORD_W-1:0] res;
      logic [1:0]         osel_eff;
      f        = choose_function(v, exp_q[0]);
      sum      = arith_181(f.sel, v.a, v.m, f.cin);
      res      = f.logic_m ? logic_181(f.sel, v.a, v.m) : sum[`WORD_W-1:0];
      co_e     = sum[`WORD_W];
      osel_eff = v.flags[3] ? v.osel : 2'b00;
      case (osel_eff)
         2'b01:   ob_e = {co_e, res[`WORD_W-1:1]};
         2'b10:   ob_e = {res[`WORD_W-2:0], exp_q[`WORD_W-1]};
         2'b11:   ob_e = {res[`WORD_W-1], res[`WORD_W-1:1]};
         default: ob_e = res;
      endcase
      if (v.flags[1])
         exp_q = {res[0], exp_q[`WORD_W-1:1]};
      else if (v.flags[0])
         exp_q = {exp_q[`WORD_W-2:0], ~res[`WORD_W-1]};
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [`WORD_W-1:0] expected,
                              input logic [`WORD_W-1:0] actual);
      check_count++;
      assert (actual === expected) else begin
         $display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
         error_count++;
      end
   endtask

   task automatic run_vec(input vec_t v, input string name);
      logic [`WORD_W-1:0] ob_e;
      logic               co_e;
      if (v.q_load) begin
         @(posedge clk);
         q_load <= 1'b1;
         a      <= v.q_pre;
         exp_q   = v.q_pre;
      end
      @(posedge clk);
      q_load <= 1'b0;
      a      <= v.a;
      m      <= v.m;
      ir     <= build_ir(v);
      iralu  <= v.flags[3];
      irjump <= v.flags[2];
      mul    <= v.flags[1];
      div    <= v.flags[0];
      step   <= 1'b1;
      predict(v, ob_e, co_e);
      @(posedge clk);
      step   <= 1'b0;
      irjump <= 1'b0;
      mul    <= 1'b0;
      div    <= 1'b0;
      @(negedge clk);
      check_value(name, "ob", ob_e, ob);
      check_value(name, "carry_out", co_e, carry_out);
      check_value(name, "q", exp_q, q);
   endtask

   task automatic build_table();
      add_vec("logic_not_a", $urandom, $urandom, 4'b0000, 1, 0, 2'b00, F_ALU, 0, 0);
      add_vec("logic_xor", $urandom, $urandom, 4'b0110, 1, 0, 2'b00, F_ALU, 0, 0);
      add_vec("logic_and", $urandom, $urandom, 4'b1011, 1, 0, 2'b00, F_ALU, 0, 0);
      add_vec("logic_or", $urandom, $urandom, 4'b1110, 1, 1, 2'b00, F_ALU, 0, 0);
      add_vec("logic_pass_m", $urandom, $urandom, 4'b1010, 1, 0, 2'b00, F_ALU, 0, 0);
      add_vec("logic_zero", $urandom, $urandom, 4'b0011, 1, 0, 2'b00, F_ALU, 0, 0);
      add_vec("add_carry", 32'hffff_fff0, 32'h20, 4'b1001, 0, 0, 2'b00, F_ALU, 0, 0);
      add_vec("add_cin", $urandom, $urandom, 4'b1001, 0, 1, 2'b00, F_ALU, 0, 0);
      add_vec("sub", $urandom, $urandom, 4'b0110, 0, 1, 2'b00, F_ALU, 0, 0);
      add_vec("sub_borrow", 32'd5, 32'd9, 4'b0110, 0, 1, 2'b00, F_ALU, 0, 0);
      add_vec("arith_a_plus_a", $urandom, $urandom, 4'b1100, 0, 0, 2'b00, F_ALU, 0, 0);
      add_vec("arith_dec_zero", 32'd0, $urandom, 4'b1111, 0, 0, 2'b00, F_ALU, 0, 0);
      add_vec("jump_compare", 32'd100, 32'd40, 4'b1001, 0, 1, 2'b00, F_JMP, 0, 0);
      add_vec("jump_compare_eq", 32'h1234_5678, 32'h1234_5678, 4'b1001, 0, 0, 2'b00, F_JMP, 0, 0);
      add_vec("mul_add", $urandom, $urandom, 4'b1001, 0, 0, 2'b00, F_MUL, 1, $urandom | 32'd1);
      add_vec("mul_pass", $urandom, $urandom, 4'b1001, 0, 0, 2'b00, F_MUL, 1, $urandom & ~32'd1);
      add_vec("mul_chain", $urandom, $urandom, 4'b1001, 0, 0, 2'b01, F_MUL, 0, 0);
      // Low select bits carry the inverted divide first and remainder flags.
      add_vec("div_sub_pos", $urandom & 32'h7fff_ffff, $urandom, 4'b0011, 0, 0, 2'b00, F_DIV,
              1, $urandom | 32'd1);
      add_vec("div_add_pos", $urandom & 32'h7fff_ffff, $urandom, 4'b0011, 0, 0, 2'b00, F_DIV,
              1, $urandom & ~32'd1);
      add_vec("div_add_neg", $urandom | 32'h8000_0000, $urandom, 4'b0011, 0, 0, 2'b00, F_DIV,
              1, $urandom | 32'd1);
      add_vec("div_sub_neg", $urandom | 32'h8000_0000, $urandom, 4'b0011, 0, 0, 2'b00, F_DIV,
              1, $urandom & ~32'd1);
      add_vec("div_rem", $urandom & 32'h7fff_ffff, $urandom, 4'b0001, 0, 0, 2'b00, F_DIV,
              1, $urandom & ~32'd1);
      add_vec("div_first_pass", $urandom | 32'h8000_0000, $urandom, 4'b0010, 0, 0, 2'b00, F_DIV,
              1, $urandom | 32'd1);
      add_vec("osel_right", $urandom, $urandom, 4'b1001, 0, 0, 2'b01, F_ALU, 0, 0);
      add_vec("osel_left", $urandom, $urandom, 4'b1001, 0, 1, 2'b10, F_ALU, 1, 32'h8000_0000);
      add_vec("osel_right_arith", 32'h8000_0000, $urandom, 4'b0000, 0, 0, 2'b11, F_ALU, 0, 0);
      add_vec("osel_iralu_low", $urandom, $urandom, 4'b1001, 0, 0, 2'b01, F_RAW, 0, 0);
   endtask

   initial begin
      void'($urandom(32'h3690_d89e));
      rst_n  = 1'b0;
      a      = '0;
      m      = '0;
      ir     = '0;
      iralu  = 1'b0;
      irjump = 1'b0;
      mul    = 1'b0;
      div    = 1'b0;
      step   = 1'b0;
      q_load = 1'b0;
      exp_q  = '0;
      build_table();
      cycle_limit = 3 * (RESET_CYCLES + 3 * vecs.size() + 2);
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("reset", "ob", '0, ob);
      check_value("reset", "q", '0, q);
      check_value("reset", "carry_out", '0, carry_out);
      foreach (vecs[i]) run_vec(vecs[i], names[i]);
      $display("Checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule : cadr_alu_tb

`default_nettype wire
